//--- build.f
hw/alu_pkg.sv
hw/alu_ctrl.sv
hw/adder_multifunc.sv
hw/shifter.sv
hw/result_path.sv
hw/flag_reg.sv
hw/alu_unit.sv
verification/tb_clk_gen.sv
verification/alu_unit_tb.sv

//--- Bender.yml
package:
  name: alu_unit

sources:
  - files:
      - hw/alu_pkg.sv
      - hw/alu_ctrl.sv
      - hw/adder_multifunc.sv
      - hw/shifter.sv
      - hw/result_path.sv
      - hw/flag_reg.sv
      - hw/alu_unit.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/alu_unit_tb.sv

//--- verification/alu_unit_tb.sv
/*
 * Directed testbench for the execution unit. Runs each operation through
 * a full req/ack handshake and checks result and flags against a model.
 */
`timescale 1ns/1ps

module alu_unit_tb import alu_pkg::*; ();

    localparam int N_OPS          = 88; // Handshakes in all tests
    localparam int TIMEOUT_CYCLES = 40 * N_OPS + 16;

    logic        clk;
    logic        rst_n;
    logic        req;
    instr_u      instr;
    logic [15:0] rs_data;
    logic [15:0] rt_data;
    logic        ack;
    logic [15:0] result;
    logic        flag_n;
    logic        flag_v;
    logic        flag_z;
    logic        exp_n;
    logic        exp_v;
    logic        exp_z;
    int          seed;
    int          cycles;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    alu_unit i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .ack     (ack),
        .result  (result),
        .flag_n  (flag_n),
        .flag_v  (flag_v),
        .flag_z  (flag_z)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_result(input string name, input logic [15:0] want,
                                input logic [15:0] got);
        if (got !== want) begin
            $display("MISMATCH %s: expected result %h, actual %h", name, want, got);
            $display("TEST FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flags(input string name, input logic wn, input logic wv,
                               input logic wz, input logic gn, input logic gv,
                               input logic gz);
        if ({gn, gv, gz} !== {wn, wv, wz}) begin
            $display("MISMATCH %s: expected NVZ %b%b%b, actual %b%b%b",
                     name, wn, wv, wz, gn, gv, gz);
            $display("TEST FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Returns {overflow, result}
    function automatic logic [16:0] model_op(input logic [3:0] op, input logic [7:0] low,
                                             input logic [15:0] a, input logic [15:0] b);
        int          sa;
        int          sb;
        int          s;
        logic [15:0] r;
        logic [31:0] dbl;
        logic        ov;
        sa = $signed(a);
        sb = $signed(b);
        ov = 1'b0;
        r  = 16'hDEAD;
        case (op)
            OP_ADD,
            OP_SUB: begin
                s  = (op == OP_ADD) ? sa + sb : sa - sb;
                ov = (s > 32767) || (s < -32768);
                r  = (s > 32767) ? 16'h7FFF : (s < -32768) ? 16'h8000 : s[15:0];
            end
            OP_RED: begin
                s = $signed(a[15:8]) + $signed(a[7:0]) + $signed(b[15:8]) + $signed(b[7:0]);
                r = s[15:0];
            end
            OP_PADDSB: begin
                for (int i = 0; i < 4; i++) begin
                    s = $signed(a[4*i +: 4]) + $signed(b[4*i +: 4]);
                    r[4*i +: 4] = (s > 7) ? 4'h7 : (s < -8) ? 4'h8 : s[3:0];
                end
            end
            OP_LW,
            OP_SW: begin
                s = 2 * $signed(low[3:0]);
                r = a + s[15:0];
            end
            OP_SLL: r = a << low[3:0];
            OP_SRA: r = $signed(a) >>> low[3:0];
            OP_ROR: begin
                dbl = {a, a} >> low[3:0];
                r   = dbl[15:0];
            end
            OP_XOR: r = a ^ b;
            OP_LLB: r = {a[15:8], low};
            OP_LHB: r = {low, a[7:0]};
            default: r = 16'hDEAD;
        endcase
        return {ov, r};
    endfunction

    // Runs one four-phase handshake and holds req for hold extra cycles
    task automatic do_op(input string name, input logic [3:0] op, input logic [7:0] low,
                         input logic [15:0] a, input logic [15:0] b, input int hold);
        logic [16:0] want;
        want = model_op(op, low, a, b);
        if (op == OP_ADD || op == OP_SUB) begin
            exp_n = want[15];
            exp_v = want[16];
        end
        if (op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR})
            exp_z = (want[15:0] == 16'h0000);
        @(negedge clk);
        instr   = {op, 4'h1, low};
        rs_data = a;
        rt_data = b;
        req     = 1'b1;
        while (!ack) @(negedge clk);
        check_result(name, want[15:0], result);
        check_flags(name, exp_n, exp_v, exp_z, flag_n, flag_v, flag_z);
        rs_data = ~a; // Operands may change once ack is up
        repeat (hold) begin
            @(negedge clk);
            if (ack !== 1'b1)
                stop_with_error({name, ": ack dropped while req was still high"});
            check_result(name, want[15:0], result);
        end
        req = 1'b0;
        @(negedge clk); // ack falls at the first edge that sees req low
        if (ack !== 1'b0)
            stop_with_error({name, ": ack still high one cycle after req dropped"});
    endtask

    task automatic test_add_sub();
        logic [15:0] a;
        logic [15:0] b;
        if (ack !== 1'b0)
            stop_with_error("ack is high after reset");
        check_result("reset", 16'h0000, result);
        check_flags("reset", 1'b0, 1'b0, 1'b0, flag_n, flag_v, flag_z);
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            do_op("add_rand", OP_ADD, 8'h00, a, b, 0);
            do_op("sub_rand", OP_SUB, 8'h00, a, b, 0);
        end
        do_op("add_sat_pos", OP_ADD, 8'h00, 16'h7000, 16'h7000, 0);
        do_op("add_sat_neg", OP_ADD, 8'h00, 16'h8000, 16'h9000, 0);
        do_op("add_zero", OP_ADD, 8'h00, 16'h1234, 16'hEDCC, 0);
        do_op("sub_zero", OP_SUB, 8'h00, 16'h5555, 16'h5555, 0);
    endtask

    task automatic test_adder_modes();
        do_op("flag_preset", OP_ADD, 8'h00, 16'h8000, 16'h8000, 0); // N=1 V=1 Z=0
        do_op("paddsb_mix", OP_PADDSB, 8'h00, 16'h7381, 16'h1F8F, 0);
        do_op("paddsb_rand", OP_PADDSB, 8'h00, 16'h4C2E, 16'h5A97, 0);
        do_op("red_pos", OP_RED, 8'h00, 16'h7F7F, 16'h7F7F, 0);
        do_op("red_neg", OP_RED, 8'h00, 16'h8081, 16'hFF10, 0);
        do_op("lw_pos", OP_LW, 8'h07, 16'h1000, 16'h0000, 0);
        do_op("lw_neg", OP_LW, 8'h08, 16'h0010, 16'h0000, 0); // Zero address
        do_op("sw_pos", OP_SW, 8'h03, 16'hFFFE, 16'h0000, 0);
        do_op("sw_neg", OP_SW, 8'h0F, 16'h0000, 16'h0000, 0);
    endtask

    task automatic test_shifts();
        logic [15:0] a;
        for (int amt = 0; amt < 16; amt++) begin
            a = (amt == 0) ? 16'h0000 : 16'($random(seed)); // amt 0 gives a Z=1 case
            do_op("sll", OP_SLL, 8'(amt), a, 16'h0000, 0);
            do_op("sra", OP_SRA, 8'(amt), a | 16'h8000, 16'h0000, 0);
            do_op("ror", OP_ROR, 8'(amt), a, 16'h0000, 0);
        end
    endtask

    task automatic test_logic_bad();
        do_op("xor_mix", OP_XOR, 8'h00, 16'hF0F0, 16'h0FF0, 0);
        do_op("xor_zero", OP_XOR, 8'h00, 16'hA5A5, 16'hA5A5, 0);
        do_op("llb", OP_LLB, 8'h3C, 16'hAB12, 16'h0000, 0);
        do_op("lhb", OP_LHB, 8'hC3, 16'hAB12, 16'h0000, 0);
        do_op("flag_clear", OP_ADD, 8'h00, 16'h1234, 16'hEDCC, 0); // N=0 V=0 Z=1
        for (int op = 12; op < 16; op++)
            do_op("undefined", 4'(op), 8'h00, 16'h7000, 16'h7000, 0); // Adder overflows
    endtask

    task automatic test_handshake();
        do_op("hold_req", OP_ADD, 8'h00, 16'h0102, 16'h0304, 5);
        do_op("after_hold", OP_SUB, 8'h00, 16'h0010, 16'h0020, 0);
    endtask

    initial begin
        seed    = 80;
        cycles  = 0;
        req     = 1'b0;
        instr   = '0;
        rs_data = 16'h0000;
        rt_data = 16'h0000;
        exp_n   = 1'b0;
        exp_v   = 1'b0;
        exp_z   = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        test_add_sub();
        test_adder_modes();
        test_shifts();
        test_logic_bad();
        test_handshake();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verification/tb_clk_gen.sv
/*
 * Testbench clock and reset. 8 ns clock, reset held low for 16 cycles.
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk); // Release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule

//--- hw/alu_unit.sv
/*
 * Execution unit top. Handshake control plus adder, shifter,
 * result path and flag register.
 */
`timescale 1ns/1ps

module alu_unit import alu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  instr_u      instr,
    input  logic [15:0] rs_data,
    input  logic [15:0] rt_data,
    output logic        ack,
    output logic [15:0] result,
    output logic        flag_n,
    output logic        flag_v,
    output logic        flag_z
);

    logic [2:0]  add_mode;
    logic [1:0]  shift_mode;
    logic [2:0]  res_sel;
    logic        load;
    logic        upd_nv;
    logic        upd_z;
    logic [15:0] add_out;
    logic        ovfl;
    logic [15:0] shift_out;
    logic [15:0] res_next;

    alu_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .instr      (instr),
        .ack        (ack),
        .add_mode   (add_mode),
        .shift_mode (shift_mode),
        .res_sel    (res_sel),
        .load       (load),
        .upd_nv     (upd_nv),
        .upd_z      (upd_z)
    );

    adder_multifunc i_adder (
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .imm4     (instr.r.imm4),
        .add_mode (add_mode),
        .add_out  (add_out),
        .ovfl     (ovfl)
    );

    shifter i_shifter (
        .shift_in   (rs_data),
        .shift_amt  (instr.r.imm4), // Amount from the r view
        .shift_mode (shift_mode),
        .shift_out  (shift_out)
    );

    result_path i_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .imm8      (instr.i.imm8), // Byte from the i view
        .add_out   (add_out),
        .shift_out (shift_out),
        .res_sel   (res_sel),
        .load      (load),
        .res_next  (res_next),
        .result    (result)
    );

    flag_reg i_flags (
        .clk      (clk),
        .rst_n    (rst_n),
        .res_next (res_next),
        .ovfl     (ovfl),
        .upd_nv   (upd_nv),
        .upd_z    (upd_z),
        .flag_n   (flag_n),
        .flag_v   (flag_v),
        .flag_z   (flag_z)
    );

endmodule

//--- hw/flag_reg.sv
/*
 * N, V and Z flag register with separate update enables.
 */
`timescale 1ns/1ps

module flag_reg (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] res_next,
    input  logic        ovfl,
    input  logic        upd_nv,
    input  logic        upd_z,
    output logic        flag_n,
    output logic        flag_v,
    output logic        flag_z
);

    logic z_next;

    assign z_next = (res_next == 16'h0000);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
        end else begin
            if (upd_nv) begin
                flag_n <= res_next[15]; // Sign of saturated result
                flag_v <= ovfl;
            end
            if (upd_z)
                flag_z <= z_next;
        end
    end

endmodule

//--- hw/result_path.sv
/*
 * Result path. Forms XOR and byte-merge results, selects the result
 * source and holds the result register.
 */
`timescale 1ns/1ps

module result_path import alu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] rs_data,
    input  logic [15:0] rt_data,
    input  logic [7:0]  imm8,
    input  logic [15:0] add_out,
    input  logic [15:0] shift_out,
    input  logic [2:0]  res_sel,
    input  logic        load,
    output logic [15:0] res_next,
    output logic [15:0] result
);

    logic [15:0] xor_out;
    logic [15:0] llb_out;
    logic [15:0] lhb_out;

    assign xor_out = rs_data ^ rt_data;
    assign llb_out = {rs_data[15:8], imm8}; // Replace low byte
    assign lhb_out = {imm8, rs_data[7:0]};  // Replace high byte

    always_comb begin
        case (res_sel)
            SEL_ADD:   res_next = add_out;
            SEL_SHIFT: res_next = shift_out;
            SEL_XOR:   res_next = xor_out;
            SEL_LLB:   res_next = llb_out;
            SEL_LHB:   res_next = lhb_out;
            default:   res_next = RES_BAD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            result <= 16'h0000;
        else if (load)
            result <= res_next;
    end

    a_sel_known: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(res_sel));

endmodule

//--- hw/shifter.sv
/*
 * Four-stage barrel shifter for SLL, SRA and ROR by a 4-bit amount.
 */
`timescale 1ns/1ps

module shifter import alu_pkg::*; (
    input  logic [15:0] shift_in,
    input  logic [3:0]  shift_amt,
    input  logic [1:0]  shift_mode,
    output logic [15:0] shift_out
);

    logic [15:0] stage;

    // Stage i shifts by 2**i when amount bit i is set
    always_comb begin
        stage = shift_in;
        for (int i = 0; i < 4; i++) begin
            if (shift_amt[i]) begin
                case (shift_mode)
                    SH_SLL:  stage = stage << (1 << i);
                    SH_SRA:  stage = $signed(stage) >>> (1 << i);
                    SH_ROR:  stage = (stage >> (1 << i)) | (stage << (16 - (1 << i)));
                    default: stage = stage; // Unused mode passes through
                endcase
            end
        end
    end

    assign shift_out = stage;

endmodule

//--- hw/adder_multifunc.sv
/*
 * Multi-function adder. Saturating add/sub, nibble-parallel PADDSB,
 * byte reduction and LW/SW address add.
 */
`timescale 1ns/1ps

module adder_multifunc import alu_pkg::*; (
    input  logic [15:0] rs_data,
    input  logic [15:0] rt_data,
    input  logic [3:0]  imm4,
    input  logic [2:0]  add_mode,
    output logic [15:0] add_out,
    output logic        ovfl
);

    logic [15:0] b_eff;
    logic [15:0] sum;
    logic        sat_pos;
    logic        sat_neg;
    logic [15:0] paddsb_out;
    logic [9:0]  red_sum;
    logic [15:0] addr_out;

    // Two's complement subtract as a + ~b + 1
    assign b_eff   = (add_mode == ADD_SUB) ? ~rt_data : rt_data;
    assign sum     = rs_data + b_eff + {15'b0, add_mode == ADD_SUB};
    assign sat_pos = !rs_data[15] && !b_eff[15] && sum[15];
    assign sat_neg = rs_data[15] && b_eff[15] && !sum[15];

    always_comb begin : paddsb_blk
        logic [3:0] na;
        logic [3:0] nb;
        logic [3:0] ns;
        for (int i = 0; i < 4; i++) begin
            na = rs_data[4*i +: 4];
            nb = rt_data[4*i +: 4];
            ns = na + nb;
            if (!na[3] && !nb[3] && ns[3])
                paddsb_out[4*i +: 4] = 4'h7; // Clamp high
            else if (na[3] && nb[3] && !ns[3])
                paddsb_out[4*i +: 4] = 4'h8; // Clamp low
            else
                paddsb_out[4*i +: 4] = ns;
        end
    end

    // Signed sum of four bytes fits in 10 bits
    assign red_sum = {{2{rs_data[15]}}, rs_data[15:8]} + {{2{rs_data[7]}}, rs_data[7:0]}
                   + {{2{rt_data[15]}}, rt_data[15:8]} + {{2{rt_data[7]}}, rt_data[7:0]};

    assign addr_out = rs_data + {{11{imm4[3]}}, imm4, 1'b0}; // Word offset

    always_comb begin
        ovfl = 1'b0;
        case (add_mode)
            ADD_PLAIN,
            ADD_SUB: begin
                ovfl    = sat_pos || sat_neg;
                add_out = sat_pos ? 16'h7FFF : (sat_neg ? 16'h8000 : sum);
            end
            ADD_RED:    add_out = {{6{red_sum[9]}}, red_sum};
            ADD_PADDSB: add_out = paddsb_out;
            ADD_ADDR:   add_out = addr_out;
            default:    add_out = sum;
        endcase
    end

endmodule

//--- hw/alu_ctrl.sv
/*
 * Execution unit control. Runs the four-phase req/ack handshake and
 * decodes the opcode into datapath modes and flag update enables.
 */
`timescale 1ns/1ps

module alu_ctrl import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req,
    input  instr_u     instr,
    output logic       ack,
    output logic [2:0] add_mode,
    output logic [1:0] shift_mode,
    output logic [2:0] res_sel,
    output logic       load,
    output logic       upd_nv,
    output logic       upd_z
);

    typedef enum logic {
        S_IDLE = 1'b0,
        S_ACK  = 1'b1
    } state_t;

    state_t state;
    logic   nv_op; // Opcode writes N and V
    logic   z_op;  // Opcode writes Z

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (req) state <= S_ACK;
                S_ACK:   if (!req) state <= S_IDLE; // Hold while req stays high
                default: state <= S_IDLE;
            endcase
        end
    end

    assign ack    = (state == S_ACK);
    assign load   = (state == S_IDLE) && req; // Accept edge only
    assign upd_nv = load && nv_op;
    assign upd_z  = load && z_op;

    always_comb begin
        add_mode   = ADD_PLAIN;
        shift_mode = SH_SLL;
        res_sel    = SEL_ADD;
        nv_op      = 1'b0;
        z_op       = 1'b0;
        case (instr.r.opcode)
            OP_ADD:    begin nv_op = 1'b1; z_op = 1'b1; end
            OP_SUB:    begin add_mode = ADD_SUB; nv_op = 1'b1; z_op = 1'b1; end
            OP_XOR:    begin res_sel = SEL_XOR; z_op = 1'b1; end
            OP_RED:    add_mode = ADD_RED;
            OP_SLL:    begin res_sel = SEL_SHIFT; z_op = 1'b1; end
            OP_SRA:    begin res_sel = SEL_SHIFT; shift_mode = SH_SRA; z_op = 1'b1; end
            OP_ROR:    begin res_sel = SEL_SHIFT; shift_mode = SH_ROR; z_op = 1'b1; end
            OP_PADDSB: add_mode = ADD_PADDSB;
            OP_LW,
            OP_SW:     add_mode = ADD_ADDR;
            OP_LLB:    res_sel = SEL_LLB;
            OP_LHB:    res_sel = SEL_LHB;
            default:   res_sel = SEL_BAD; // Flags untouched
        endcase
    end

    // ack only follows a sampled request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    // One load per handshake, and ack is up right after it
    a_load_single: assert property (@(posedge clk) disable iff (!rst_n)
        load |=> (ack && !load));

endmodule

//--- hw/alu_pkg.sv
/*
 * Shared definitions for the 16-bit execution unit: opcodes, datapath
 * mode codes, result-select codes and the instruction word layout.
 */
package alu_pkg;

    localparam logic [3:0] OP_ADD    = 4'h0;
    localparam logic [3:0] OP_SUB    = 4'h1;
    localparam logic [3:0] OP_XOR    = 4'h2;
    localparam logic [3:0] OP_RED    = 4'h3;
    localparam logic [3:0] OP_SLL    = 4'h4;
    localparam logic [3:0] OP_SRA    = 4'h5;
    localparam logic [3:0] OP_ROR    = 4'h6;
    localparam logic [3:0] OP_PADDSB = 4'h7;
    localparam logic [3:0] OP_LW     = 4'h8;
    localparam logic [3:0] OP_SW     = 4'h9;
    localparam logic [3:0] OP_LLB    = 4'hA;
    localparam logic [3:0] OP_LHB    = 4'hB;

    localparam logic [2:0] ADD_PLAIN  = 3'd0;
    localparam logic [2:0] ADD_SUB    = 3'd1;
    localparam logic [2:0] ADD_RED    = 3'd2;
    localparam logic [2:0] ADD_PADDSB = 3'd3;
    localparam logic [2:0] ADD_ADDR   = 3'd4; // LW/SW effective address

    localparam logic [1:0] SH_SLL = 2'd0;
    localparam logic [1:0] SH_SRA = 2'd1;
    localparam logic [1:0] SH_ROR = 2'd2;

    localparam logic [2:0] SEL_ADD   = 3'd0;
    localparam logic [2:0] SEL_SHIFT = 3'd1;
    localparam logic [2:0] SEL_XOR   = 3'd2;
    localparam logic [2:0] SEL_LLB   = 3'd3;
    localparam logic [2:0] SEL_LHB   = 3'd4;
    localparam logic [2:0] SEL_BAD   = 3'd5;

    localparam logic [15:0] RES_BAD = 16'hDEAD; // Undefined opcode marker

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] imm4; // Shift amount or signed word offset
    } instr_r_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] rd;
        logic [7:0] imm8; // Byte for LLB/LHB
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage
